// ==== hw/axi_lite_pkg.sv ====
// AXI-lite bus widths, response codes and the register window base
package axi_lite_pkg;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;

    // window start, low AXI_WINDOW_BITS bits are bank plus index
    localparam logic [AXI_ADDR_WIDTH-1:0] AXI_BASE_ADDR = 32'h4000_0000;
    localparam int AXI_WINDOW_BITS = 9;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

endpackage

// ==== hw/opl3_axi_bridge.sv ====
// AXI-lite slave bridge: window decode, write priority, register commands and read strobes
`timescale 1ns/1ps

module opl3_axi_bridge (
    input  logic                                       clk,
    input  logic                                       arst_n,
    // write address
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0]    awaddr,
    input  logic [2:0]                                 awprot,  // accepted, never checked
    input  logic                                       awvalid,
    output logic                                       awready,
    // write data
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0]    wdata,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH/8-1:0]  wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,
    // write response
    output axi_lite_pkg::resp_t                        bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    // read address
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0]    araddr,
    input  logic [2:0]                                 arprot,  // accepted, never checked
    input  logic                                       arvalid,
    output logic                                       arready,
    // read data
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0]    rdata,
    output axi_lite_pkg::resp_t                        rresp,
    output logic                                       rvalid,
    input  logic                                       rready,
    // command queue side
    output logic                                       push,
    output opl3_pkg::reg_cmd_t                         cmd,
    input  logic                                       full,
    input  logic                                       empty,
    // register file read port
    output logic                                       rd,
    output logic                                       rd_bank,
    output logic [opl3_pkg::REG_FILE_ADDRESS_WIDTH-1:0] rd_addr,
    input  logic                                       rd_valid,
    input  logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0]   data_out
);
    import opl3_pkg::*;
    import axi_lite_pkg::*;

    logic                           aw_hit;    // write address inside window
    logic                           ar_hit;    // read address inside window
    logic                           wr_hs;     // aw and w beats taken together
    logic                           rd_hs;     // ar beat taken
    logic                           rd_busy;   // in-window read waiting on rd_valid
    logic                           rvalid_q;  // held response, master not ready yet
    resp_t                          rresp_q;
    logic [REG_FILE_DATA_WIDTH-1:0] rdata_q;
    logic [REG_FILE_DATA_WIDTH-1:0] rbyte;     // byte presented on the r channel

    // upper address bits must match the base, low bits are bank + index
    assign aw_hit = (awaddr[AXI_ADDR_WIDTH-1:AXI_WINDOW_BITS] ==
                     AXI_BASE_ADDR[AXI_ADDR_WIDTH-1:AXI_WINDOW_BITS]);
    assign ar_hit = (araddr[AXI_ADDR_WIDTH-1:AXI_WINDOW_BITS] ==
                     AXI_BASE_ADDR[AXI_ADDR_WIDTH-1:AXI_WINDOW_BITS]);

    // write side, aw and w accepted as a pair
    assign wr_hs   = awvalid && wvalid && !bvalid && !full;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign push    = wr_hs && aw_hit && wstrb[0];  // low lane off means no-op write

    always_comb begin
        cmd.bank    = awaddr[REG_FILE_ADDRESS_WIDTH];  // bit 8 picks the bank
        cmd.address = awaddr[REG_FILE_ADDRESS_WIDTH-1:0];
        cmd.data    = wdata[REG_FILE_DATA_WIDTH-1:0];  // only byte lane 0 is used
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;  // response taken
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            if (aw_hit) begin
                bresp <= RESP_OKAY;
            end else begin
                bresp <= RESP_SLVERR;  // outside window, nothing queued
            end
        end
    end

    // read side; writes win, and a read only goes once the queue has drained
    // wr_hs low also rules out a push in this cycle
    assign rd_hs   = arvalid && !rvalid && !rd_busy && empty && !wr_hs;
    assign arready = rd_hs;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd      <= 1'b0;
            rd_busy <= 1'b0;
        end else begin
            rd <= rd_hs && ar_hit;  // one-cycle strobe to the register file
            if (rd_hs && ar_hit) begin
                rd_busy <= 1'b1;
            end else if (rd_valid) begin
                rd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rd_bank <= araddr[REG_FILE_ADDRESS_WIDTH];
            rd_addr <= araddr[REG_FILE_ADDRESS_WIDTH-1:0];
        end
    end

    // r channel goes valid with rd_valid and is held until rready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_valid) begin
            rvalid_q <= !rready;       // hold only if not taken right away
        end else if (rd_hs && !ar_hit) begin
            rvalid_q <= 1'b1;          // error reply, no register access
        end else if (rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            rdata_q <= data_out;       // capture register byte
            rresp_q <= RESP_OKAY;
        end else if (rd_hs && !ar_hit) begin
            rdata_q <= '0;
            rresp_q <= RESP_SLVERR;
        end
    end

    assign rvalid = rvalid_q || rd_valid;
    assign rbyte  = rd_valid ? data_out : rdata_q;
    assign rdata  = {{(AXI_DATA_WIDTH-REG_FILE_DATA_WIDTH){1'b0}}, rbyte};  // zero-extend

    always_comb begin
        if (rd_valid) begin
            rresp = RESP_OKAY;
        end else begin
            rresp = rresp_q;
        end
    end

endmodule

// ==== hw/opl3_pkg.sv ====
// register file geometry, write queue depth and the register write command struct
package opl3_pkg;

    // register file shape
    localparam int REG_FILE_ADDRESS_WIDTH = 8;  // index inside one bank
    localparam int REG_FILE_DATA_WIDTH    = 8;  // one byte per register
    localparam int NUM_BANKS              = 2;  // A1 selects the bank

    // write queue between host port and register file
    localparam int CMD_FIFO_DEPTH = 4;

    // one queued register write, 17 bits
    typedef struct packed {
        logic                              bank;     // bank select
        logic [REG_FILE_ADDRESS_WIDTH-1:0] address;  // register index
        logic [REG_FILE_DATA_WIDTH-1:0]    data;     // byte to write
    } reg_cmd_t;

endpackage

// ==== hw/opl3_reg_file.sv ====
// two banks of byte registers, drained from the write queue, with a registered read port
`timescale 1ns/1ps

module opl3_reg_file (
    input  logic                                        clk,
    input  logic                                        arst_n,
    // write queue side
    input  logic                                        empty,
    output logic                                        pop,
    input  opl3_pkg::reg_cmd_t                          cmd,
    // read port
    input  logic                                        rd,
    input  logic                                        rd_bank,
    input  logic [opl3_pkg::REG_FILE_ADDRESS_WIDTH-1:0] rd_addr,
    output logic [opl3_pkg::REG_FILE_DATA_WIDTH-1:0]    data_out,
    output logic                                        rd_valid
);
    import opl3_pkg::*;

    localparam int REGS_PER_BANK = 2**REG_FILE_ADDRESS_WIDTH;

    logic [REG_FILE_DATA_WIDTH-1:0] regs [NUM_BANKS][REGS_PER_BANK];

    // drain one command per cycle whenever there is one
    assign pop = !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                for (int a = 0; a < REGS_PER_BANK; a++) begin
                    regs[b][a] <= '0;  // synth state starts silent
                end
            end
        end else if (pop) begin
            regs[cmd.bank][cmd.address] <= cmd.data;
        end
    end

    // read strobe answered one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd;
        end
    end

    // no same-cycle write hazard, reads only issue with the queue empty
    always_ff @(posedge clk) begin
        if (rd) begin
            data_out <= regs[rd_bank][rd_addr];
        end
    end

endmodule

// ==== hw/opl3_reg_subsys.sv ====
// host register port top: AXI-lite bridge, write command queue and register banks
`timescale 1ns/1ps

module opl3_reg_subsys (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0]    awaddr,
    input  logic [2:0]                                 awprot,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0]    wdata,
    input  logic [axi_lite_pkg::AXI_DATA_WIDTH/8-1:0]  wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,
    output axi_lite_pkg::resp_t                        bresp,
    output logic                                       bvalid,
    input  logic                                       bready,
    input  logic [axi_lite_pkg::AXI_ADDR_WIDTH-1:0]    araddr,
    input  logic [2:0]                                 arprot,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0]    rdata,
    output axi_lite_pkg::resp_t                        rresp,
    output logic                                       rvalid,
    input  logic                                       rready
);
    import opl3_pkg::*;

    // bridge to queue
    logic     push;
    reg_cmd_t cmd;
    logic     full;
    logic     empty;
    // queue to register file
    logic     pop;
    reg_cmd_t pop_cmd;
    // bridge to register file reads
    logic                              rd;
    logic                              rd_bank;
    logic [REG_FILE_ADDRESS_WIDTH-1:0] rd_addr;
    logic                              rd_valid;
    logic [REG_FILE_DATA_WIDTH-1:0]    data_out;

    opl3_axi_bridge u_bridge (
        .clk      (clk),
        .arst_n   (arst_n),
        .awaddr   (awaddr),
        .awprot   (awprot),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arprot   (arprot),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .push     (push),
        .cmd      (cmd),
        .full     (full),
        .empty    (empty),
        .rd       (rd),
        .rd_bank  (rd_bank),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .data_out (data_out)
    );

    reg_cmd_fifo #(
        .DEPTH (CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .push_cmd (cmd),
        .pop      (pop),
        .pop_cmd  (pop_cmd),
        .full     (full),
        .empty    (empty)
    );

    opl3_reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .empty    (empty),
        .pop      (pop),
        .cmd      (pop_cmd),
        .rd       (rd),
        .rd_bank  (rd_bank),
        .rd_addr  (rd_addr),
        .data_out (data_out),
        .rd_valid (rd_valid)
    );

endmodule

// ==== hw/reg_cmd_fifo.sv ====
// synchronous queue of register write commands with push/pop strobes and full/empty levels
`timescale 1ns/1ps

module reg_cmd_fifo #(
    parameter int DEPTH = opl3_pkg::CMD_FIFO_DEPTH  // power of two, 2 or more
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  opl3_pkg::reg_cmd_t push_cmd,
    input  logic               pop,
    output opl3_pkg::reg_cmd_t pop_cmd,
    output logic               full,
    output logic               empty
);
    import opl3_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    reg_cmd_t         mem [DEPTH];  // command storage
    logic [PTR_W:0]   wr_ptr;       // msb is the wrap bit
    logic [PTR_W:0]   rd_ptr;
    logic             do_push;
    logic             do_pop;

    // guard against misuse even though the neighbours obey full/empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // same index, wrap bits tell full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_cmd;
        end
    end

    assign pop_cmd = mem[rd_ptr[PTR_W-1:0]];  // oldest entry, valid while !empty

endmodule

// ==== opl3_reg_subsys.f ====
hw/opl3_pkg.sv
hw/axi_lite_pkg.sv
hw/reg_cmd_fifo.sv
hw/opl3_reg_file.sv
hw/opl3_axi_bridge.sv
hw/opl3_reg_subsys.sv
verif/tb_clk_gen.sv
verif/opl3_reg_subsys_assert.sv
verif/tb_opl3_reg_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_opl3_reg_subsys \
    -f opl3_reg_subsys.f -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "^Verification passed$" sim.log \
    && { echo "simulation PASS"; exit 0; } \
    || { echo "simulation FAIL"; exit 1; }

// ==== verif/opl3_reg_subsys_assert.sv ====
// concurrent checks on queue push, read strobe timing and AXI response hold, bound to the top
`timescale 1ns/1ps

module opl3_reg_subsys_assert (
    input logic clk,
    input logic arst_n,
    input logic push,
    input logic full,
    input logic rd,
    input logic rd_valid,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready
);

    // bridge must respect queue back-pressure
    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full)) else $error("push seen while command queue full");

    // register file answers exactly one cycle after the strobe
    rd_valid_after_rd: assert property (@(posedge clk) disable iff (!arst_n)
        rd |=> rd_valid) else $error("rd_valid missing one cycle after rd");
    rd_valid_needs_rd: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> $past(rd)) else $error("rd_valid without rd one cycle before");

    // responses held until the master takes them
    bvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
    rvalid_held: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

endmodule

bind opl3_reg_subsys opl3_reg_subsys_assert u_assert (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .full     (full),
    .rd       (rd),
    .rd_valid (rd_valid),
    .bvalid   (bvalid),
    .bready   (bready),
    .rvalid   (rvalid),
    .rready   (rready)
);

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset source: 20 ns clock, reset held low for 8 cycles
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;  // free running
    end

    initial begin
        arst_n = 1'b0;                    // reset from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;                 // release just after an edge
    end

endmodule

// ==== verif/tb_opl3_reg_subsys.sv ====
// testbench top: stimulus table, AXI-lite master tasks, shadow register model, watchdog, summary
`timescale 1ns/1ps

module tb_opl3_reg_subsys;
    import opl3_pkg::*;
    import axi_lite_pkg::*;

    localparam int NUM_ROWS        = 21;
    localparam int HS_LIMIT        = 30;             // cycles allowed per beat
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 40;

    // one table row
    typedef struct packed {
        logic                           is_read;
        logic [AXI_ADDR_WIDTH-1:0]      addr;
        logic                           strb0;      // wstrb[0]
        logic [REG_FILE_DATA_WIDTH-1:0] data;       // 0 picks a random byte
        logic [1:0]                     hold;       // cycles bready stays low
        resp_t                          resp;       // expected b or r response
        logic                           with_prev;  // read starts together with the write above
    } test_row_t;

    logic                        clk;
    logic                        arst_n;
    logic [AXI_ADDR_WIDTH-1:0]   awaddr;
    logic [2:0]                  awprot;
    logic                        awvalid;
    logic                        awready;
    logic [AXI_DATA_WIDTH-1:0]   wdata;
    logic [AXI_DATA_WIDTH/8-1:0] wstrb;
    logic                        wvalid;
    logic                        wready;
    resp_t                       bresp;
    logic                        bvalid;
    logic                        bready;
    logic [AXI_ADDR_WIDTH-1:0]   araddr;
    logic [2:0]                  arprot;
    logic                        arvalid;
    logic                        arready;
    logic [AXI_DATA_WIDTH-1:0]   rdata;
    resp_t                       rresp;
    logic                        rvalid;
    logic                        rready;

    test_row_t                      rows [NUM_ROWS];
    logic [REG_FILE_DATA_WIDTH-1:0] shadow [NUM_BANKS][256];  // predicted register contents
    logic [31:0]                    lcg_state;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    opl3_reg_subsys u_opl3_reg_subsys (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arprot  (arprot),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // middle bits, better spread than the low ones
    endfunction

    task automatic load_table();
        // reset state, both banks
        rows[0]  = '{1'b1, 32'h4000_0005, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        rows[1]  = '{1'b1, 32'h4000_0105, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        // same index in both banks
        rows[2]  = '{1'b0, 32'h4000_0010, 1'b1, 8'h5a, 2'd0, RESP_OKAY, 1'b0};
        rows[3]  = '{1'b0, 32'h4000_0110, 1'b1, 8'h00, 2'd1, RESP_OKAY, 1'b0};
        rows[4]  = '{1'b1, 32'h4000_0010, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        rows[5]  = '{1'b1, 32'h4000_0110, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        // low lane strobe off
        rows[6]  = '{1'b0, 32'h4000_0010, 1'b0, 8'hff, 2'd0, RESP_OKAY, 1'b0};
        rows[7]  = '{1'b1, 32'h4000_0010, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        // bit 9 set, aliases 0x010 if decode were too loose
        rows[8]  = '{1'b0, 32'h4000_0210, 1'b1, 8'h33, 2'd0, RESP_SLVERR, 1'b0};
        rows[9]  = '{1'b1, 32'h4000_0210, 1'b0, 8'h00, 2'd0, RESP_SLVERR, 1'b0};
        rows[10] = '{1'b0, 32'h5000_0010, 1'b1, 8'h77, 2'd2, RESP_SLVERR, 1'b0};
        rows[11] = '{1'b1, 32'h4000_0010, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        // six writes in a row with bready stalled
        rows[12] = '{1'b0, 32'h4000_0020, 1'b1, 8'h11, 2'd3, RESP_OKAY, 1'b0};
        rows[13] = '{1'b0, 32'h4000_0120, 1'b1, 8'h00, 2'd2, RESP_OKAY, 1'b0};
        rows[14] = '{1'b0, 32'h4000_0020, 1'b1, 8'h22, 2'd3, RESP_OKAY, 1'b0};
        rows[15] = '{1'b0, 32'h4000_0021, 1'b1, 8'h00, 2'd1, RESP_OKAY, 1'b0};
        rows[16] = '{1'b0, 32'h4000_0120, 1'b1, 8'h44, 2'd3, RESP_OKAY, 1'b0};
        rows[17] = '{1'b0, 32'h4000_0020, 1'b1, 8'h66, 2'd2, RESP_OKAY, 1'b0};
        // read presented in the same cycle as the last write
        rows[18] = '{1'b1, 32'h4000_0020, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b1};
        rows[19] = '{1'b1, 32'h4000_0120, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
        rows[20] = '{1'b1, 32'h4000_0021, 1'b0, 8'h00, 2'd0, RESP_OKAY, 1'b0};
    endtask

    // aw and w together, then b with bready held low for hold cycles
    task automatic axi_write(input logic [AXI_ADDR_WIDTH-1:0] addr, input logic [7:0] data,
                             input logic strb0, input logic [1:0] hold,
                             output resp_t resp, output bit ok);
        int n;
        ok      = 1'b0;
        resp    = RESP_OKAY;
        awaddr  = addr;
        wdata   = {24'h0, data};
        wstrb   = {3'b000, strb0};
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        n       = 0;
        @(negedge clk);
        while (!(awready && wready) && n < HS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (n >= HS_LIMIT) begin
            $display("write beat to %08h was not accepted within %0d cycles", addr, HS_LIMIT);
            return;
        end
        repeat (hold) @(posedge clk);
        #1 bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid && n < HS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        resp = bresp;  // stable at the falling edge
        ok   = bvalid;
        @(posedge clk);
        #1 bready = 1'b0;
        if (!ok) begin
            $display("no write response for %08h within %0d cycles", addr, HS_LIMIT);
        end
    endtask

    task automatic axi_read(input logic [AXI_ADDR_WIDTH-1:0] addr, output resp_t resp,
                            output logic [AXI_DATA_WIDTH-1:0] data, output bit ok);
        int n;
        ok      = 1'b0;
        resp    = RESP_OKAY;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        n       = 0;
        @(negedge clk);
        while (!arready && n < HS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #1 arvalid = 1'b0;
        if (n >= HS_LIMIT) begin
            rready = 1'b0;
            $display("read address %08h was not accepted within %0d cycles", addr, HS_LIMIT);
            return;
        end
        n = 0;
        @(negedge clk);
        while (!rvalid && n < HS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        resp = rresp;
        data = rdata;
        ok   = rvalid;
        @(posedge clk);
        #1 rready = 1'b0;
        if (!ok) begin
            $display("no read data for %08h within %0d cycles", addr, HS_LIMIT);
        end
    endtask

    initial begin : main
        int                        errors;
        int                        passed;
        test_row_t                 row;
        logic [7:0]                wr_byte;
        logic [7:0]                exp_byte;
        resp_t                     wr_resp;
        resp_t                     rd_resp;
        logic [AXI_DATA_WIDTH-1:0] rd_data;
        bit                        wr_ok;
        bit                        rd_ok;
        bit                        early_rd;
        bit                        row_ok;
        errors    = 0;
        passed    = 0;
        lcg_state = 32'd9393;
        awaddr    = '0;
        awprot    = 3'b000;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arprot    = 3'b000;
        arvalid   = 1'b0;
        rready    = 1'b0;
        rd_resp   = RESP_OKAY;
        rd_data   = '0;
        rd_ok     = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int a = 0; a < 256; a++) begin
                shadow[b][a] = 8'h00;  // reset value
            end
        end
        load_table();
        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            row    = rows[r];
            row_ok = 1'b1;
            if (!row.is_read) begin
                wr_byte  = (row.data == 8'h00) ? next_rand() : row.data;
                early_rd = 1'b0;
                if (r + 1 < NUM_ROWS) begin
                    early_rd = rows[r+1].is_read && rows[r+1].with_prev;
                end
                // flagged read competes with this write from its first cycle
                fork
                    axi_write(row.addr, wr_byte, row.strb0, row.hold, wr_resp, wr_ok);
                    if (early_rd) begin
                        axi_read(rows[r+1].addr, rd_resp, rd_data, rd_ok);
                    end
                join
                if (!wr_ok) begin
                    row_ok = 1'b0;
                end else if (wr_resp != row.resp) begin
                    $display("[FAIL] time %0t bresp expected %0d got %0d",
                             $time, row.resp, wr_resp);
                    row_ok = 1'b0;
                end
                // only accepted writes with the low lane on change the model
                if (row.resp == RESP_OKAY && row.strb0) begin
                    shadow[row.addr[8]][row.addr[7:0]] = wr_byte;
                end
            end else begin
                // write wins, so a read launched with it sees the new byte
                exp_byte = (row.resp == RESP_OKAY) ? shadow[row.addr[8]][row.addr[7:0]] : 8'h00;
                if (!row.with_prev) begin
                    axi_read(row.addr, rd_resp, rd_data, rd_ok);
                end
                if (!rd_ok) begin
                    row_ok = 1'b0;
                end else begin
                    if (rd_resp != row.resp) begin
                        $display("[FAIL] time %0t rresp expected %0d got %0d",
                                 $time, row.resp, rd_resp);
                        row_ok = 1'b0;
                    end
                    if (rd_data != {24'h0, exp_byte}) begin
                        $display("[FAIL] time %0t rdata expected %08h got %08h",
                                 $time, {24'h0, exp_byte}, rd_data);
                        row_ok = 1'b0;
                    end
                end
            end
            if (row_ok) begin
                passed++;
                $display("row %0d %s %08h ok", r, row.is_read ? "read " : "write", row.addr);
            end else begin
                errors++;
                $display("row %0d %s %08h FAILED", r, row.is_read ? "read " : "write", row.addr);
            end
        end
        $display("rows run %0d, passed %0d, failed %0d", NUM_ROWS, passed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // budget of 40 cycles per row, reset included
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule
